/* cpuController.f */
verilog/isaPkg.sv
verilog/ctrlPkg.sv
verilog/instrDecode.sv
verilog/cpuSequencer.sv
verilog/aluSelect.sv
verilog/storeSelect.sv
verilog/cpuController.sv
sim/clkGen.sv
sim/cpuControllerTb.sv

/* run.sh */
#!/bin/sh
# Compile the testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/100ps \
    -f cpuController.f --top-module cpuControllerTb -o simv > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qxF "PASS: all tests" sim.log; then
    exit 0
fi
exit 1

/* sim/cpuControllerTb.sv */
`default_nettype none

module cpuControllerTb;

    timeunit 1ns;
    timeprecision 100ps;

    logic                clk;
    logic                rst;
    logic                resetReq;
    isaPkg::opcodeT      opcode;
    isaPkg::flagsT       flags;
    logic                stall;
    ctrlPkg::stateT      state;
    ctrlPkg::aluFuncT    aluFunc;
    ctrlPkg::aluSrcT     aluA;
    ctrlPkg::aluSrcT     aluB;
    ctrlPkg::memAddrSelT memAddr;
    ctrlPkg::writeSrcT   writeDataSource;
    isaPkg::flagsT       inF;
    logic                re;
    logic                we;
    logic                saveOpcode;
    logic                saveMem1;
    logic                saveMem2;
    logic                saveResult;
    logic                enPC;
    logic                enA;
    logic                enB;
    logic                enC;
    logic                enSP;
    logic                initSP;
    logic                enF;
    logic                sourceF;

    string testName;
    int    errorCount;
    int    testErrors;      // Error count when the test started
    int    passCount;
    int    failCount;

    clkGen clkGen_i (
        .resetReq(resetReq),
        .clk(clk),
        .rst(rst)
    );

    cpuController cpuController_i (
        .*
    );

    task automatic checkState(ctrlPkg::stateT exp);
        if (state !== exp) begin
            $display("error %s: state expected %s actual %s", testName, exp.name(), state.name());
            errorCount++;
        end
    endtask

    task automatic checkAluSrc(string what, ctrlPkg::aluSrcT exp, ctrlPkg::aluSrcT act);
        if (act !== exp) begin
            $display("error %s: %s expected %0d actual %0d", testName, what, exp, act);
            errorCount++;
        end
    endtask

    task automatic checkAluFunc(ctrlPkg::aluFuncT exp);
        if (aluFunc !== exp) begin
            $display("error %s: aluFunc expected %0d actual %0d", testName, exp, aluFunc);
            errorCount++;
        end
    endtask

    task automatic checkMemAddr(ctrlPkg::memAddrSelT exp);
        if (memAddr !== exp) begin
            $display("error %s: memAddr expected %0d actual %0d", testName, exp, memAddr);
            errorCount++;
        end
    endtask

    task automatic checkWriteSrc(ctrlPkg::writeSrcT exp);
        if (writeDataSource !== exp) begin
            $display("error %s: writeDataSource expected %0d actual %0d",
                     testName, exp, writeDataSource);
            errorCount++;
        end
    endtask

    task automatic checkFlags(isaPkg::flagsT exp);
        if (inF !== exp) begin
            $display("error %s: inF expected %b actual %b", testName, exp, inF);
            errorCount++;
        end
    endtask

    task automatic checkBit(string what, logic exp, logic act);
        if (act !== exp) begin
            $display("error %s: %s expected %b actual %b", testName, what, exp, act);
            errorCount++;
        end
    endtask

    task automatic checkStrobesLow();
        checkBit("re", 1'b0, re);
        checkBit("we", 1'b0, we);
        checkBit("saveOpcode", 1'b0, saveOpcode);
        checkBit("saveMem1", 1'b0, saveMem1);
        checkBit("saveMem2", 1'b0, saveMem2);
        checkBit("saveResult", 1'b0, saveResult);
        checkBit("enPC", 1'b0, enPC);
        checkBit("enA", 1'b0, enA);
        checkBit("enB", 1'b0, enB);
        checkBit("enC", 1'b0, enC);
        checkBit("enSP", 1'b0, enSP);
        checkBit("initSP", 1'b0, initSP);
        checkBit("enF", 1'b0, enF);
        checkBit("sourceF", 1'b0, sourceF);
    endtask

    task automatic checkAbsStore();
        checkBit("we", 1'b1, we);
        checkWriteSrc(ctrlPkg::WRITE_FROM_RES);
        checkMemAddr(ctrlPkg::MEM_FROM_ALU);
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic stepTo(ctrlPkg::stateT exp);
        nextCycle();
        @(negedge clk);
        checkState(exp);
    endtask

    task automatic beginInstr(isaPkg::opcodeT op, isaPkg::flagsT fl);
        opcode = op;
        flags  = fl;
        @(negedge clk);
        checkState(ctrlPkg::FETCH);
    endtask

    task automatic endInstr();
        nextCycle();
        checkState(ctrlPkg::FETCH);     // State register settled since the edge
    endtask

    task automatic waitResetDone();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (rst && cycles < 20);
        if (rst) begin
            $display("timeout in %s: reset still active after 20 cycles", testName);
            errorCount++;
        end
    endtask

    task automatic waitState(ctrlPkg::stateT target);
        int cycles;
        cycles = 0;
        do begin
            nextCycle();
            cycles++;
        end while (state != target && cycles < 20);
        if (state != target) begin
            $display("timeout in %s: state %s not reached within 20 cycles",
                     testName, target.name());
            errorCount++;
        end
    endtask

    task automatic startTest(string name);
        testName   = name;
        testErrors = errorCount;
    endtask

    task automatic endTest();
        if (errorCount == testErrors) begin
            passCount++;
            $display("test %s: ok", testName);
        end else begin
            failCount++;
            $display("test %s: %0d errors", testName, errorCount - testErrors);
        end
    endtask

    task automatic testResetFetch();
        startTest("reset and fetch");
        waitResetDone();
        checkState(ctrlPkg::START);
        checkBit("enSP", 1'b1, enSP);
        checkBit("initSP", 1'b1, initSP);
        checkBit("we", 1'b0, we);
        checkBit("re", 1'b0, re);
        checkBit("enPC", 1'b0, enPC);
        nextCycle();                    // START lasts one cycle
        beginInstr(16'h0007, 4'h0);     // A type without a write
        checkBit("re", 1'b1, re);
        checkBit("saveOpcode", 1'b1, saveOpcode);
        checkBit("enPC", 1'b1, enPC);
        checkMemAddr(ctrlPkg::MEM_FROM_PC);
        checkAluSrc("aluA", ctrlPkg::ALUA_PC, aluA);
        checkAluSrc("aluB", ctrlPkg::ALUB_ONE, aluB);
        checkAluFunc(ctrlPkg::ALU_ADD);
        stepTo(ctrlPkg::ATYPE);
        endInstr();
        endTest();
    endtask

    task automatic testAType();
        isaPkg::fieldT src;
        isaPkg::fieldT dest;
        logic [1:0]    regB;
        logic [3:0]    func;
        int            i;
        startTest("A type register");
        for (i = 0; i < 6; i++) begin
            src  = 3'($urandom_range(3, 0));
            dest = 3'($urandom_range(3, 1));
            regB = 2'($urandom);
            func = 4'($urandom);
            beginInstr({4'b0000, src, func, regB, dest}, 4'($urandom));
            stepTo(ctrlPkg::ATYPE);
            checkAluFunc(func);
            checkAluSrc("aluA", {1'b0, src}, aluA);
            checkAluSrc("aluB", {2'b00, regB}, aluB);
            checkBit("enF", 1'b1, enF);
            checkBit("enA", dest == 3'd1, enA);
            checkBit("enB", dest == 3'd2, enB);
            checkBit("enC", dest == 3'd3, enC);
            checkBit("enSP", 1'b0, enSP);
            endInstr();
        end
        endTest();
    endtask

    task automatic testAbsWrite();
        startTest("absolute write");
        // I type field 5 is both the absolute read and the absolute write
        beginInstr({2'b01, 2'($urandom), 3'd5, 9'($urandom)}, 4'($urandom));
        stepTo(ctrlPkg::RABS1);
        checkBit("saveMem2", 1'b1, saveMem2);
        stepTo(ctrlPkg::RABS2);
        stepTo(ctrlPkg::RABS3);
        stepTo(ctrlPkg::ITYPE);
        checkBit("saveResult", 1'b1, saveResult);
        stepTo(ctrlPkg::WABS1);
        stepTo(ctrlPkg::WABS2);
        stepTo(ctrlPkg::WABS3);
        checkAbsStore();
        endInstr();
        // SI type with immediate source and absolute destination
        beginInstr({4'b0001, 3'd4, 2'($urandom), 3'd5, 4'($urandom)}, 4'($urandom));
        stepTo(ctrlPkg::RIMMED);
        checkBit("re", 1'b1, re);
        checkBit("saveMem1", 1'b1, saveMem1);
        checkBit("enPC", 1'b1, enPC);
        stepTo(ctrlPkg::SITYPE);
        stepTo(ctrlPkg::WABS1);
        stepTo(ctrlPkg::WABS2);
        stepTo(ctrlPkg::WABS3);
        checkAbsStore();
        endInstr();
        endTest();
    endtask

    task automatic testFlagAndJump();
        isaPkg::flagsT fl;
        isaPkg::flagsT expF;
        logic [1:0]    idx;
        logic          wantBit;
        int            i;
        int            j;
        startTest("F type and J type");
        for (i = 0; i < 4; i++) begin
            idx = 2'(i);
            fl  = 4'($urandom);     // Same flags for both wanted values
            for (j = 0; j < 2; j++) begin
                wantBit = 1'(j);
                beginInstr({4'b0010, 1'b0, wantBit, idx, 8'($urandom)}, fl);
                if (fl[idx] == wantBit) begin
                    stepTo(ctrlPkg::JFLAG);
                    checkBit("enPC", 1'b1, enPC);
                end
                endInstr();
            end
        end
        for (j = 0; j < 2; j++) begin
            idx       = 2'($urandom_range(3, 0));
            wantBit   = 1'(j);
            fl        = 4'($urandom);
            expF      = fl;
            expF[idx] = wantBit;    // FLS sets, FLC clears
            beginInstr({4'b0010, 1'b1, wantBit, idx, 8'($urandom)}, fl);
            stepTo(ctrlPkg::FETCH);
            checkBit("enF", 1'b1, enF);
            checkBit("sourceF", 1'b1, sourceF);
            checkFlags(expF);
            endInstr();
        end
        beginInstr({1'b1, 15'($urandom)}, 4'($urandom));
        stepTo(ctrlPkg::JTYPE);
        checkAluFunc(ctrlPkg::ALU_JUMP);
        checkBit("enPC", 1'b1, enPC);
        endInstr();
        endTest();
    endtask

    task automatic testPushPop();
        startTest("push and pop");
        beginInstr({4'b0011, 1'b0, 2'($urandom), 2'b00, 7'($urandom)}, 4'($urandom));
        stepTo(ctrlPkg::PUSH1);
        checkBit("we", 1'b1, we);
        checkMemAddr(ctrlPkg::MEM_FROM_SP);
        stepTo(ctrlPkg::PUSH2);
        checkBit("enSP", 1'b1, enSP);
        checkAluFunc(ctrlPkg::ALU_SUB);
        endInstr();
        beginInstr({4'b0011, 3'd2, 2'b01, 7'($urandom)}, 4'($urandom));     // Pop to B
        stepTo(ctrlPkg::POP1);
        checkBit("re", 1'b1, re);
        checkBit("saveMem1", 1'b1, saveMem1);
        stepTo(ctrlPkg::POP2);
        checkBit("enB", 1'b1, enB);
        endInstr();
        endTest();
    endtask

    task automatic testStall();
        isaPkg::fieldT src;
        isaPkg::fieldT dest;
        logic [1:0]    regB;
        logic [3:0]    func;
        int            i;
        startTest("stall");
        src  = 3'($urandom_range(3, 0));
        dest = 3'($urandom_range(3, 1));
        regB = 2'($urandom);
        func = 4'($urandom);
        beginInstr({4'b0000, src, func, regB, dest}, 4'($urandom));
        nextCycle();
        stall = 1'b1;
        for (i = 0; i < 5; i++) begin
            @(negedge clk);
            checkState(ctrlPkg::ATYPE);
            checkAluFunc(func);
            checkAluSrc("aluA", {1'b0, src}, aluA);
            checkAluSrc("aluB", {2'b00, regB}, aluB);
            checkBit("enF", 1'b1, enF);
            checkBit("enA", dest == 3'd1, enA);
            checkBit("enB", dest == 3'd2, enB);
            checkBit("enC", dest == 3'd3, enC);
            nextCycle();
        end
        stall = 1'b0;
        endInstr();
        endTest();
    endtask

    task automatic testInvalid();
        int i;
        startTest("invalid read mode");
        beginInstr({2'b01, 2'($urandom), 3'd7, 9'($urandom)}, 4'($urandom));
        for (i = 0; i < 4; i++) begin
            stepTo(ctrlPkg::HALT);
            checkStrobesLow();
        end
        nextCycle();
        resetReq = 1'b1;
        @(negedge clk);
        checkState(ctrlPkg::START);     // Reset acts without a clock edge
        nextCycle();
        resetReq = 1'b0;
        waitResetDone();
        waitState(ctrlPkg::FETCH);
        endTest();
    endtask

    initial begin
        void'($urandom(18758));
        opcode     = '0;
        flags      = '0;
        stall      = 1'b0;
        resetReq   = 1'b0;
        errorCount = 0;
        testErrors = 0;
        passCount  = 0;
        failCount  = 0;
        testName   = "";

        testResetFetch();
        testAType();
        testAbsWrite();
        testFlagAndJump();
        testPushPop();
        testStall();
        testInvalid();

        $display("tests passed %0d failed %0d", passCount, failCount);
        if (errorCount == 0 && failCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/clkGen.sv */
`default_nettype none

module clkGen (
    input  wire  resetReq,
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;      // 10 ns period
    end

    // Reset for 3 cycles at start and after each request
    initial begin
        rst = 1'b1;
        forever begin
            repeat (3) @(posedge clk);
            #3 rst = 1'b0;          // Released mid-cycle
            @(posedge resetReq);
            rst = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* verilog/cpuController.sv */
`default_nettype none

module cpuController (
    input  wire                     clk,
    input  wire                     rst,
    input  wire isaPkg::opcodeT     opcode,
    input  wire isaPkg::flagsT      flags,
    input  wire                     stall,
    output wire ctrlPkg::stateT     state,
    output wire ctrlPkg::aluFuncT   aluFunc,
    output wire ctrlPkg::aluSrcT    aluA,
    output wire ctrlPkg::aluSrcT    aluB,
    output wire ctrlPkg::memAddrSelT memAddr,
    output wire                     re,
    output wire                     we,
    output wire ctrlPkg::writeSrcT  writeDataSource,
    output wire                     saveOpcode,
    output wire                     saveMem1,
    output wire                     saveMem2,
    output wire                     saveResult,
    output wire                     enPC,
    output wire                     enA,
    output wire                     enB,
    output wire                     enC,
    output wire                     enSP,
    output wire                     initSP,
    output wire                     enF,
    output wire                     sourceF,
    output wire isaPkg::flagsT      inF
);

    isaPkg::instrClassT instrClass;     // Decoded class of the current opcode
    logic               pendingFlagOp;  // FLS/FLC seen in FETCH

    instrDecode instrDecode_i (
        .*
    );

    cpuSequencer cpuSequencer_i (
        .*
    );

    aluSelect aluSelect_i (
        .*
    );

    storeSelect storeSelect_i (
        .*
    );

endmodule

`default_nettype wire

/* verilog/storeSelect.sv */
`default_nettype none

module storeSelect (
    input  wire ctrlPkg::stateT state,
    input  wire isaPkg::opcodeT opcode,
    input  wire isaPkg::flagsT  flags,
    input  wire                 pendingFlagOp,
    output ctrlPkg::memAddrSelT memAddr,
    output logic                re,
    output logic                we,
    output ctrlPkg::writeSrcT   writeDataSource,
    output logic                saveOpcode,
    output logic                saveMem1,
    output logic                saveMem2,
    output logic                saveResult,
    output logic                enPC,
    output logic                enA,
    output logic                enB,
    output logic                enC,
    output logic                enSP,
    output logic                initSP,
    output logic                enF,
    output logic                sourceF,
    output isaPkg::flagsT       inF
);

    isaPkg::fieldT dest;
    isaPkg::flagsT flagMask;    // Bit picked by the flag index

    assign dest     = isaPkg::destField(opcode);
    assign flagMask = 4'b0001 << opcode[9:8];

    always_comb begin
        memAddr         = ctrlPkg::MEM_FROM_PC;
        re              = 1'b0;
        we              = 1'b0;
        writeDataSource = ctrlPkg::WRITE_FROM_ALU;
        saveOpcode      = 1'b0;
        saveMem1        = 1'b0;
        saveMem2        = 1'b0;
        saveResult      = 1'b0;
        enPC            = 1'b0;
        enA             = 1'b0;
        enB             = 1'b0;
        enC             = 1'b0;
        enSP            = 1'b0;
        initSP          = 1'b0;
        enF             = 1'b0;
        sourceF         = 1'b0;
        inF             = '0;
        case (state)
            ctrlPkg::START: begin
                enSP   = 1'b1;
                initSP = 1'b1;
            end
            ctrlPkg::FETCH: begin
                re         = 1'b1;
                saveOpcode = 1'b1;
                enPC       = 1'b1;
                if (pendingFlagOp) begin
                    enF     = 1'b1;
                    sourceF = 1'b1;     // Flags taken from inF
                    inF     = opcode[10] ? (flags | flagMask) : (flags & ~flagMask);
                end
            end
            ctrlPkg::ATYPE, ctrlPkg::ITYPE, ctrlPkg::SITYPE: enF = 1'b1;
            ctrlPkg::JTYPE, ctrlPkg::JFLAG: enPC = 1'b1;
            ctrlPkg::PUSH1: begin
                we      = 1'b1;
                memAddr = ctrlPkg::MEM_FROM_SP;
            end
            ctrlPkg::PUSH2: enSP = 1'b1;
            ctrlPkg::POP1: begin
                enSP     = 1'b1;
                memAddr  = ctrlPkg::MEM_FROM_ALU;   // Read at SP + 1
                re       = 1'b1;
                saveMem1 = 1'b1;
            end
            ctrlPkg::RIMMED, ctrlPkg::RABS2, ctrlPkg::WABS2: begin
                re       = 1'b1;
                saveMem1 = 1'b1;
                enPC     = 1'b1;
            end
            ctrlPkg::RABS1, ctrlPkg::WABS1: begin
                re       = 1'b1;
                saveMem2 = 1'b1;    // High address word
                enPC     = 1'b1;
            end
            ctrlPkg::RADDRESS: begin
                memAddr  = ctrlPkg::MEM_FROM_A;
                re       = 1'b1;
                saveMem1 = 1'b1;
            end
            ctrlPkg::RABS3: begin
                memAddr  = ctrlPkg::MEM_FROM_ALU;
                re       = 1'b1;
                saveMem1 = 1'b1;
            end
            ctrlPkg::WABS3: begin
                memAddr         = ctrlPkg::MEM_FROM_ALU;
                we              = 1'b1;
                writeDataSource = ctrlPkg::WRITE_FROM_RES;
            end
            default: begin
            end
        endcase

        // Result destination of the states that produce one
        if (state inside {ctrlPkg::ATYPE, ctrlPkg::ITYPE, ctrlPkg::SITYPE, ctrlPkg::POP2}) begin
            case (dest)
                isaPkg::DEST_0: enSP = (state == ctrlPkg::ITYPE);   // SP only for I type
                isaPkg::DEST_A: enA = 1'b1;
                isaPkg::DEST_B: enB = 1'b1;
                isaPkg::DEST_C: enC = 1'b1;
                isaPkg::DEST_ADR: begin
                    we      = 1'b1;
                    memAddr = ctrlPkg::MEM_FROM_A;
                end
                isaPkg::DEST_ABS: begin
                    saveResult = 1'b1;      // Hold result until WABS3
                    saveMem1   = 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/aluSelect.sv */
`default_nettype none

module aluSelect (
    input  wire ctrlPkg::stateT state,
    input  wire isaPkg::opcodeT opcode,
    output ctrlPkg::aluFuncT    aluFunc,
    output ctrlPkg::aluSrcT     aluA,
    output ctrlPkg::aluSrcT     aluB
);

    isaPkg::fieldT   src;
    ctrlPkg::aluSrcT srcA;  // Register or memory operand on input A

    assign src  = isaPkg::srcField(opcode);
    assign srcA = src[2] ? ctrlPkg::ALUA_MEM : ctrlPkg::aluSrcT'({2'b00, src[1:0]});

    always_comb begin
        aluFunc = ctrlPkg::ALU_ADD;
        aluA    = '0;
        aluB    = '0;
        case (state)
            ctrlPkg::FETCH, ctrlPkg::RIMMED, ctrlPkg::RABS1, ctrlPkg::RABS2,
            ctrlPkg::WABS1, ctrlPkg::WABS2: begin
                aluA = ctrlPkg::ALUA_PC;    // PC + 1
                aluB = ctrlPkg::ALUB_ONE;
            end
            ctrlPkg::ATYPE: begin
                aluA    = srcA;
                aluB    = {2'b00, opcode[4:3]};
                aluFunc = opcode[8:5];      // Function given by the instruction
            end
            ctrlPkg::ITYPE: begin
                if (src == isaPkg::DEST_0) begin
                    aluA = ctrlPkg::ALUA_SP;    // Field 0 means SP here
                end else begin
                    aluA = srcA;
                end
                aluB    = ctrlPkg::ALUB_OP;
                aluFunc = {opcode[8], opcode[8], opcode[13:12]};
            end
            ctrlPkg::SITYPE: begin
                aluA    = srcA;
                aluB    = ctrlPkg::ALUB_OP;
                aluFunc = {2'b10, opcode[8:7]};     // Shift group
            end
            ctrlPkg::JTYPE: begin
                aluA    = ctrlPkg::ALUA_PC;
                aluB    = ctrlPkg::ALUB_ADDR;
                aluFunc = ctrlPkg::ALU_JUMP;
            end
            ctrlPkg::JFLAG: begin
                aluA = ctrlPkg::ALUA_PC;    // PC plus offset
                aluB = ctrlPkg::ALUB_OP;
            end
            ctrlPkg::PUSH1: begin
                aluA = srcA;
                aluB = ctrlPkg::ALUB_ZERO;
            end
            ctrlPkg::PUSH2: begin
                aluA    = ctrlPkg::ALUA_SP;
                aluB    = ctrlPkg::ALUB_ONE;
                aluFunc = ctrlPkg::ALU_SUB;     // SP - 1
            end
            ctrlPkg::POP1: begin
                aluA = ctrlPkg::ALUA_SP;    // SP + 1
                aluB = ctrlPkg::ALUB_ONE;
            end
            ctrlPkg::POP2: begin
                aluA = ctrlPkg::ALUA_MEM;
                aluB = ctrlPkg::ALUB_ZERO;
            end
            ctrlPkg::RABS3, ctrlPkg::WABS3: begin
                aluA = ctrlPkg::ALUA_HIMEM;     // Absolute address from saved words
                aluB = ctrlPkg::ALUB_ZERO;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/cpuSequencer.sv */
`default_nettype none

module cpuSequencer (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     stall,
    input  wire isaPkg::opcodeT     opcode,
    input  wire isaPkg::instrClassT instrClass,
    output ctrlPkg::stateT          state,
    output logic                    pendingFlagOp
);

    ctrlPkg::stateT nextState;
    ctrlPkg::stateT classState;     // Main state of the decoded instruction
    isaPkg::fieldT  src;
    logic           readsOperand;
    logic           absWrite;

    assign src           = isaPkg::srcField(opcode);
    assign readsOperand  = instrClass inside {isaPkg::ATYPE, isaPkg::ITYPE,
                                              isaPkg::SITYPE, isaPkg::PUSH};
    assign absWrite      = (isaPkg::destField(opcode) == isaPkg::DEST_ABS);
    assign pendingFlagOp = (state == ctrlPkg::FETCH) && (instrClass == isaPkg::FLAGOP);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ctrlPkg::START;
        end else if (!stall) begin
            state <= nextState;
        end
    end

    always_comb begin
        case (instrClass)
            isaPkg::ATYPE:  classState = ctrlPkg::ATYPE;
            isaPkg::ITYPE:  classState = ctrlPkg::ITYPE;
            isaPkg::SITYPE: classState = ctrlPkg::SITYPE;
            isaPkg::JTYPE:  classState = ctrlPkg::JTYPE;
            isaPkg::JFLAG:  classState = ctrlPkg::JFLAG;
            isaPkg::PUSH:   classState = ctrlPkg::PUSH1;
            isaPkg::POP:    classState = ctrlPkg::POP1;
            isaPkg::FLAGOP, isaPkg::SKIP: classState = ctrlPkg::FETCH;  // Flags change in FETCH
            default:        classState = ctrlPkg::HALT;
        endcase
    end

    always_comb begin
        nextState = ctrlPkg::HALT;
        case (state)
            ctrlPkg::START: nextState = ctrlPkg::FETCH;
            ctrlPkg::FETCH: begin
                if (!readsOperand || !src[2]) begin     // Register operand
                    nextState = classState;
                end else begin
                    case (src)
                        isaPkg::READ_IMM: nextState = ctrlPkg::RIMMED;
                        isaPkg::READ_ABS: nextState = ctrlPkg::RABS1;
                        isaPkg::READ_ADR: nextState = ctrlPkg::RADDRESS;
                        default:          nextState = ctrlPkg::HALT;
                    endcase
                end
            end
            ctrlPkg::RIMMED, ctrlPkg::RADDRESS, ctrlPkg::RABS3: nextState = classState;
            ctrlPkg::RABS1: nextState = ctrlPkg::RABS2;
            ctrlPkg::RABS2: nextState = ctrlPkg::RABS3;
            ctrlPkg::ATYPE, ctrlPkg::ITYPE, ctrlPkg::SITYPE, ctrlPkg::POP2: begin
                if (absWrite) begin
                    nextState = ctrlPkg::WABS1;
                end else begin
                    nextState = ctrlPkg::FETCH;
                end
            end
            ctrlPkg::WABS1: nextState = ctrlPkg::WABS2;
            ctrlPkg::WABS2: nextState = ctrlPkg::WABS3;
            ctrlPkg::WABS3: nextState = ctrlPkg::FETCH;
            ctrlPkg::PUSH1: nextState = ctrlPkg::PUSH2;
            ctrlPkg::POP1:  nextState = ctrlPkg::POP2;
            ctrlPkg::JTYPE, ctrlPkg::JFLAG, ctrlPkg::PUSH2: begin
                nextState = ctrlPkg::FETCH;
            end
            default: nextState = ctrlPkg::HALT;     // HALT stays until reset
        endcase
    end

endmodule

`default_nettype wire

/* verilog/instrDecode.sv */
`default_nettype none

module instrDecode (
    input  wire isaPkg::opcodeT     opcode,
    input  wire isaPkg::flagsT      flags,
    output isaPkg::instrClassT      instrClass
);

    isaPkg::fieldT      src;
    isaPkg::fieldT      dest;
    isaPkg::instrClassT baseClass;  // Class before operand checks

    assign src  = isaPkg::srcField(opcode);
    assign dest = isaPkg::destField(opcode);

    always_comb begin
        baseClass = isaPkg::INVALID;
        if (opcode[15:12] == 4'b0000) begin
            baseClass = isaPkg::ATYPE;
        end else if (opcode[15:14] == 2'b01) begin
            baseClass = isaPkg::ITYPE;
        end else if (opcode[15]) begin
            baseClass = isaPkg::JTYPE;
        end else if (opcode[15:12] == 4'b0001) begin
            baseClass = isaPkg::SITYPE;
        end else if (opcode[15:12] == 4'b0010) begin
            if (opcode[11]) begin
                baseClass = isaPkg::FLAGOP;
            end else if (flags[opcode[9:8]] == opcode[10]) begin   // Wanted flag value
                baseClass = isaPkg::JFLAG;
            end else begin
                baseClass = isaPkg::SKIP;
            end
        end else if (opcode[15:12] == 4'b0011) begin
            case (opcode[8:7])
                2'b00:   baseClass = isaPkg::PUSH;
                2'b01:   baseClass = isaPkg::POP;
                default: baseClass = isaPkg::INVALID;   // Former call and return
            endcase
        end
    end

    // Read mode 7 and destination 6 are not supported
    always_comb begin
        instrClass = baseClass;
        case (baseClass)
            isaPkg::ATYPE, isaPkg::ITYPE, isaPkg::SITYPE: begin
                if (src == isaPkg::READ_BAD || dest == isaPkg::DEST_UNUSED) begin
                    instrClass = isaPkg::INVALID;
                end
            end
            isaPkg::PUSH: begin
                if (src == isaPkg::READ_BAD) begin
                    instrClass = isaPkg::INVALID;
                end
            end
            isaPkg::POP: begin
                if (dest == isaPkg::DEST_UNUSED) begin
                    instrClass = isaPkg::INVALID;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/ctrlPkg.sv */
`default_nettype none

package ctrlPkg;

    typedef enum logic [5:0] {
        START,
        FETCH,
        ATYPE,
        ITYPE,
        SITYPE,
        JTYPE,
        JFLAG,
        FLAGOP,
        PUSH1,
        PUSH2,
        POP1,
        POP2,
        RIMMED,     // Operand read sub-sequences
        RADDRESS,
        RABS1,
        RABS2,
        RABS3,
        WABS1,      // Absolute write sub-sequence
        WABS2,
        WABS3,
        HALT = 6'd63
    } stateT;

    typedef logic [1:0] memAddrSelT;

    localparam memAddrSelT MEM_FROM_PC  = 2'd0;
    localparam memAddrSelT MEM_FROM_A   = 2'd1;
    localparam memAddrSelT MEM_FROM_SP  = 2'd2;
    localparam memAddrSelT MEM_FROM_ALU = 2'd3;

    // Codes 0 to 3 pick a register on either input
    typedef logic [3:0] aluSrcT;

    localparam aluSrcT ALUA_PC    = 4'd4;
    localparam aluSrcT ALUA_MEM   = 4'd5;
    localparam aluSrcT ALUA_SP    = 4'd6;
    localparam aluSrcT ALUA_HIMEM = 4'd7;

    localparam aluSrcT ALUB_ONE   = 4'd4;
    localparam aluSrcT ALUB_ZERO  = 4'd5;
    localparam aluSrcT ALUB_OP    = 4'd6;   // Constant from instruction
    localparam aluSrcT ALUB_ADDR  = 4'd7;   // Jump address from instruction

    typedef logic [3:0] aluFuncT;

    localparam aluFuncT ALU_ADD  = 4'd0;
    localparam aluFuncT ALU_SUB  = 4'd2;
    localparam aluFuncT ALU_JUMP = 4'd6;

    typedef logic [3:0] writeSrcT;

    localparam writeSrcT WRITE_FROM_ALU = 4'd0;
    localparam writeSrcT WRITE_FROM_RES = 4'd1;

endpackage

`default_nettype wire

/* verilog/isaPkg.sv */
`default_nettype none

package isaPkg;

    typedef logic [15:0] opcodeT;   // One instruction word
    typedef logic [3:0]  flagsT;    // Flag register
    typedef logic [2:0]  fieldT;    // Source or destination field

    typedef enum logic [3:0] {
        ATYPE,
        ITYPE,
        SITYPE,
        JTYPE,
        JFLAG,      // Conditional jump, condition true
        FLAGOP,     // FLS/FLC
        PUSH,
        POP,
        SKIP,       // Conditional jump, condition false
        INVALID
    } instrClassT;

    // Destination code 7 means no write
    localparam fieldT DEST_0      = 3'd0;
    localparam fieldT DEST_A      = 3'd1;
    localparam fieldT DEST_B      = 3'd2;
    localparam fieldT DEST_C      = 3'd3;
    localparam fieldT DEST_ADR    = 3'd4;   // Through A
    localparam fieldT DEST_ABS    = 3'd5;
    localparam fieldT DEST_UNUSED = 3'd6;

    localparam fieldT READ_IMM = 3'd4;
    localparam fieldT READ_ABS = 3'd5;
    localparam fieldT READ_ADR = 3'd6;      // Through A
    localparam fieldT READ_BAD = 3'd7;

    function automatic fieldT srcField(opcodeT op);
        return op[11:9];
    endfunction

    // A and SI type carry the destination in their own field
    function automatic fieldT destField(opcodeT op);
        if (op[15:12] == 4'b0000) begin
            return op[2:0];
        end else if (op[15:12] == 4'b0001) begin
            return op[6:4];
        end
        return op[11:9];    // I type and pop share the source field
    endfunction

endpackage

`default_nettype wire
